/* design/loadExtender.sv */
`timescale 1ns/1ps
`default_nettype none

module loadExtender (
    input  memPkg::memOp_e   memOp,      // Current memory operation
    input  logic [1:0]       byteOffset, // Low bits of the load address
    input  memPkg::busWord_u rdWord,     // Word returned by the RAM
    output logic [31:0]      loadValue   // Extended value for the register file
);

    logic [7:0]  laneByte; // Addressed byte
    logic [15:0] laneHalf; // Addressed halfword

    assign laneByte = rdWord.bytes[byteOffset]; // Lane picked by offset
    assign laneHalf = byteOffset[1] ? {rdWord.bytes[3], rdWord.bytes[2]}
                                    : {rdWord.bytes[1], rdWord.bytes[0]};

    always_comb begin
        case (memOp)
            memPkg::loadByte: begin
                loadValue = {{24{laneByte[7]}}, laneByte}; // Sign extend byte
            end
            memPkg::loadHalf: begin
                loadValue = {{16{laneHalf[15]}}, laneHalf}; // Sign extend half
            end
            memPkg::loadWord: begin
                loadValue = rdWord.word; // Straight through
            end
            memPkg::loadByteU: begin
                loadValue = {24'b0, laneByte}; // Zero extend byte
            end
            memPkg::loadHalfU: begin
                loadValue = {16'b0, laneHalf}; // Zero extend half
            end
            default: begin
                loadValue = 32'b0; // Stores and none return nothing
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/memPkg.sv */
`default_nettype none

package memPkg;

    // Memory operation codes as the control unit issues them
    typedef enum logic [3:0] {
        none      = 4'd0, // No data access this instruction
        loadByte  = 4'd1, // LB
        loadHalf  = 4'd2, // LH
        loadWord  = 4'd3, // LW
        loadByteU = 4'd4, // LBU
        loadHalfU = 4'd5, // LHU
        storeByte = 4'd6, // SB
        storeHalf = 4'd7, // SH
        storeWord = 4'd8  // SW
    } memOp_e;

    // One bus word, seen whole or lane by lane
    typedef union packed {
        logic [31:0]      word;  // Full 32-bit view
        logic [3:0][7:0]  bytes; // Lane 0 is the lowest address
    } busWord_u;

    // Handler sequencing states
    typedef enum logic [1:0] {
        fetch     = 2'd0, // Instruction read issued
        fetchWait = 2'd1, // Waiting for fetch ack
        data      = 2'd2, // Load or store issued
        dataWait  = 2'd3  // Waiting for data ack
    } handlerState_e;

endpackage

`default_nettype wire

/* design/memoryHandler.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryHandler (
    input  logic                  clk,
    input  logic                  nrst,       // Synchronous, active low
    input  logic [31:0]           pc,         // Fetch address
    input  memPkg::memOp_e        memOp,      // Memory operation of this instruction
    input  logic [31:0]           aluAddress, // Load or store byte address
    input  logic                  memSource,  // High stores FPU data
    input  logic [31:0]           regData,    // Register store data
    input  logic [31:0]           fpuData,    // FPU store data
    wbBus.master                  bus,        // Wishbone classic master port
    output memPkg::busWord_u      instr,      // Last fetched instruction
    output logic [31:0]           loadData,   // Last load result
    output logic                  freeze,     // Stall the CPU
    output logic                  done,       // Instruction memory work finished
    output memPkg::handlerState_e state       // Current phase
);

    memPkg::handlerState_e stateNext;
    logic                  started;    // Out of reset for at least one cycle
    logic                  inData;     // Data phase owns the bus
    logic                  isStore;
    logic                  isLoad;
    logic                  isHalf;
    logic                  isWordOp;
    logic                  misaligned; // Access breaks natural alignment
    memPkg::busWord_u      wrWord;     // Aligned store data
    logic [3:0]            wrSel;      // Store lane enables
    logic [31:0]           loadValue;  // Extended load result

    storeAligner i_storeAligner (
        .memOp      (memOp),
        .byteOffset (aluAddress[1:0]),
        .memSource  (memSource),
        .regData    (regData),
        .fpuData    (fpuData),
        .wrWord     (wrWord),
        .wrSel      (wrSel)
    );

    loadExtender i_loadExtender (
        .memOp      (memOp),
        .byteOffset (aluAddress[1:0]),
        .rdWord     (bus.datR),
        .loadValue  (loadValue)
    );

    assign isStore  = memOp inside {memPkg::storeByte, memPkg::storeHalf, memPkg::storeWord};
    assign isLoad   = memOp inside {memPkg::loadByte, memPkg::loadHalf, memPkg::loadWord,
                                    memPkg::loadByteU, memPkg::loadHalfU};
    assign isHalf   = memOp inside {memPkg::loadHalf, memPkg::loadHalfU, memPkg::storeHalf};
    assign isWordOp = memOp inside {memPkg::loadWord, memPkg::storeWord};
    assign inData   = (state == memPkg::data) || (state == memPkg::dataWait);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            started <= 1'b0;
            state   <= memPkg::fetch;
        end else begin
            started <= 1'b1; // First request one cycle after reset
            state   <= stateNext;
        end
    end

    always_comb begin
        stateNext = state; // Hold by default
        case (state)
            memPkg::fetch: begin
                if (started) stateNext = memPkg::fetchWait; // Request is on the bus
            end
            memPkg::fetchWait: begin
                if (bus.ack) begin
                    // Skip the data phase when there is no access
                    stateNext = (memOp == memPkg::none) ? memPkg::fetch : memPkg::data;
                end
            end
            memPkg::data: begin
                stateNext = memPkg::dataWait;
            end
            memPkg::dataWait: begin
                if (bus.ack) stateNext = memPkg::fetch; // Back for the next instruction
            end
            default: begin
                stateNext = memPkg::fetch;
            end
        endcase
    end

    // Classic cycles run back to back so the request stays up across phases
    assign bus.cyc  = started;
    assign bus.stb  = started;
    assign bus.we   = inData && isStore;                       // Only stores write
    assign bus.sel  = (inData && isStore) ? wrSel : 4'b1111;   // Reads take the whole word
    assign bus.adr  = inData ? aluAddress : pc;                // PC in fetch, ALU in data
    assign bus.datW = wrWord;

    assign done   = bus.ack && ((state == memPkg::dataWait) ||
                    ((state == memPkg::fetchWait) && (memOp == memPkg::none)));
    assign freeze = !done; // CPU only moves in the done cycle

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state == memPkg::fetchWait) && bus.ack) instr <= bus.datR; // Capture instruction
        if ((state == memPkg::dataWait) && bus.ack && isLoad) loadData <= loadValue;
    end

    assign misaligned = inData ? ((isHalf && bus.adr[0]) || (isWordOp && (bus.adr[1:0] != 2'b00)))
                               : (bus.adr[1:0] != 2'b00); // Fetch is a word access

    aMisaligned: assert property (@(posedge clk) disable iff (!nrst)
        bus.stb |-> !misaligned)
        else $error("misaligned access at %h", bus.adr);

    // Classic rule holding until the slave answers
    aStable: assert property (@(posedge clk) disable iff (!nrst)
        bus.stb && !bus.ack |=> bus.cyc && bus.stb && $stable(bus.adr) && $stable(bus.we)
                                && $stable(bus.sel) && $stable(bus.datW))
        else $error("master outputs changed before ack");

endmodule

`default_nettype wire

/* design/memorySubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memorySubsystem #(
    parameter int addrWidth  = 8, // 256 words of RAM
    parameter int waitStates = 2  // RAM wait states
) (
    input  logic                  clk,
    input  logic                  nrst,       // Synchronous, active low
    input  logic [31:0]           pc,         // Fetch address
    input  memPkg::memOp_e        memOp,      // Memory operation
    input  logic [31:0]           aluAddress, // Data byte address
    input  logic                  memSource,  // High stores FPU data
    input  logic [31:0]           regData,    // Register store data
    input  logic [31:0]           fpuData,    // FPU store data
    output logic [31:0]           instr,      // Fetched instruction
    output logic [31:0]           loadData,   // Load result
    output logic                  freeze,     // CPU stall
    output logic                  done,       // Instruction finished with memory
    output memPkg::handlerState_e state       // Handler phase for debug
);

    wbBus             bus ();    // Handler to RAM
    memPkg::busWord_u instrWord; // Instruction as a bus word

    memoryHandler i_memoryHandler (
        .clk        (clk),
        .nrst       (nrst),
        .pc         (pc),
        .memOp      (memOp),
        .aluAddress (aluAddress),
        .memSource  (memSource),
        .regData    (regData),
        .fpuData    (fpuData),
        .bus        (bus.master),
        .instr      (instrWord),
        .loadData   (loadData),
        .freeze     (freeze),
        .done       (done),
        .state      (state)
    );

    wishboneRam #(
        .addrWidth  (addrWidth),
        .waitStates (waitStates)
    ) i_wishboneRam (
        .clk  (clk),
        .nrst (nrst),
        .bus  (bus.slave)
    );

    assign instr = instrWord.word; // Plain word at the top

endmodule

`default_nettype wire

/* design/storeAligner.sv */
`timescale 1ns/1ps
`default_nettype none

module storeAligner (
    input  memPkg::memOp_e   memOp,      // Current memory operation
    input  logic [1:0]       byteOffset, // Low bits of the store address
    input  logic             memSource,  // High selects FPU data
    input  logic [31:0]      regData,    // Register file store data
    input  logic [31:0]      fpuData,    // FPU register store data
    output memPkg::busWord_u wrWord,     // Data placed on its lanes
    output logic [3:0]       wrSel       // Lanes to be written
);

    logic [31:0] srcData; // Chosen store source

    assign srcData = memSource ? fpuData : regData; // FPU or integer register

    // Sub-word data is copied to every lane so the addressed one always carries it
    always_comb begin
        wrWord.word = 32'b0; // Loads and none put nothing on the bus
        wrSel       = 4'b0000;
        case (memOp)
            memPkg::storeByte: begin
                wrWord.bytes = {4{srcData[7:0]}}; // Byte on all four lanes
                wrSel        = 4'b0001 << byteOffset; // Only the addressed lane
            end
            memPkg::storeHalf: begin
                wrWord.word = {2{srcData[15:0]}}; // Half on both halves
                wrSel       = byteOffset[1] ? 4'b1100 : 4'b0011; // Upper or lower half
            end
            memPkg::storeWord: begin
                wrWord.word = srcData; // Whole word as is
                wrSel       = 4'b1111;
            end
            default: begin
                wrWord.word = 32'b0;
                wrSel       = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/wbBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface wbBus;

    logic             cyc;  // Bus cycle in progress
    logic             stb;  // Valid transfer request
    logic             we;   // Write when high
    logic [3:0]       sel;  // Byte lane enables
    logic [31:0]      adr;  // Byte address
    memPkg::busWord_u datW; // Master to slave data
    memPkg::busWord_u datR; // Slave to master data
    logic             ack;  // One-cycle transfer done

    // Handler side
    modport master (
        output cyc, stb, we, sel, adr, datW,
        input  datR, ack
    );

    // RAM side
    modport slave (
        input  cyc, stb, we, sel, adr, datW,
        output datR, ack
    );

endinterface

`default_nettype wire

/* design/wishboneRam.sv */
`timescale 1ns/1ps
`default_nettype none

module wishboneRam #(
    parameter int addrWidth  = 8, // Word address bits
    parameter int waitStates = 2  // Extra cycles before ack
) (
    input logic clk,
    input logic nrst, // Synchronous, active low
    wbBus.slave bus   // Wishbone classic slave port
);

    localparam int cntWidth = $clog2(waitStates + 2); // Holds 0 to waitStates

    memPkg::busWord_u     mem [2**addrWidth]; // Storage array
    logic [addrWidth-1:0] wordAdr;            // Word index from byte address
    logic [cntWidth-1:0]  waitCnt;            // Cycles spent on this request

    assign wordAdr = bus.adr[addrWidth+1:2]; // Byte address to word index

    // Ack timing
    always_ff @(posedge clk) begin
        if (!nrst) begin
            bus.ack <= 1'b0;
            waitCnt <= '0;
        end else if (bus.ack) begin
            bus.ack <= 1'b0; // Single-cycle ack
            waitCnt <= '0;   // Ready for the next request
        end else if (bus.cyc && bus.stb) begin
            if (waitCnt == cntWidth'(waitStates)) begin
                bus.ack <= 1'b1; // Wait states used up
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end else begin
            waitCnt <= '0; // Request withdrawn
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (bus.cyc && bus.stb && !bus.ack) begin
            bus.datR <= mem[wordAdr]; // Valid by the ack cycle
        end
        if (bus.ack && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.sel[i]) mem[wordAdr].bytes[i] <= bus.datW.bytes[i]; // Selected lanes only
            end
        end
    end

    aAckInCycle: assert property (@(posedge clk) disable iff (!nrst)
        bus.ack |-> bus.cyc && bus.stb)
        else $error("ack without an active request");

endmodule

`default_nettype wire

/* list.f */
design/memPkg.sv
design/wbBus.sv
design/storeAligner.sv
design/loadExtender.sv
design/memoryHandler.sv
design/wishboneRam.sv
design/memorySubsystem.sv
tests/memorySubsystemTb.sv

/* tests/memorySubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memorySubsystemTb;

    localparam int waitStates    = 2;                                     // RAM wait states
    localparam int numTests      = 24;                                    // Table rows
    localparam int timeoutCycles = numTests * (2 * waitStates + 4) + 100; // Longest access per row

    logic                  clk = 1'b0;
    logic                  nrst;
    logic                  memSource;
    logic                  freeze;
    logic                  done;
    logic [31:0]           pc, aluAddress, regData, fpuData; // CPU side inputs
    logic [31:0]           instr, loadData;
    memPkg::memOp_e        memOp;
    memPkg::handlerState_e state;

    logic [31:0]    tPc   [numTests]; // Fetch address column
    memPkg::memOp_e tOp   [numTests];
    logic [31:0]    tAdr  [numTests]; // Data byte address
    logic           tSrc  [numTests]; // High picks FPU data
    logic [31:0]    tReg  [numTests];
    logic [31:0]    tFpu  [numTests];
    string          tName [numTests];
    int             tableLen = 0;

    logic [7:0]  modelMem [int];          // Reference memory, one entry per byte
    logic [31:0] rngState = 32'ha2d5_ebab;
    logic [31:0] expLoad;                 // Expected loadData
    logic        loadKnown   = 1'b0;      // No load done yet
    int          errorCount  = 0;
    int          checkCount  = 0;
    int          cycleCount  = 0;
    string       currentTest = "reset";

    memorySubsystem #(.addrWidth(8), .waitStates(waitStates)) i_memorySubsystem (.*);

    always #2 clk = ~clk; // 4 ns period

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            errorCount = errorCount + 1;
            $display("Test %s never saw done within %0d cycles", currentTest, timeoutCycles);
            $display("Checks run %0d, errors %0d", checkCount, errorCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Word around a byte address, X where the model holds nothing
    function automatic memPkg::busWord_u modelWord(input int a);
        memPkg::busWord_u w;
        int               base;
        base = a & ~3;
        for (int k = 0; k < 4; k++) begin
            w.bytes[k] = modelMem.exists(base + k) ? modelMem[base + k] : 8'hxx;
        end
        return w;
    endfunction

    function automatic logic [31:0] expectedLoad(input memPkg::memOp_e op, input int a);
        memPkg::busWord_u w;
        logic [7:0]       b;
        logic [15:0]      h;
        w = modelWord(a);
        b = w.bytes[a & 3];                             // Addressed lane
        h = (a & 2) ? w.word[31:16] : w.word[15:0];     // Addressed half
        case (op)
            memPkg::loadByte:  expectedLoad = {{24{b[7]}}, b};
            memPkg::loadByteU: expectedLoad = {24'h0, b};
            memPkg::loadHalf:  expectedLoad = {{16{h[15]}}, h};
            memPkg::loadHalfU: expectedLoad = {16'h0, h};
            default:           expectedLoad = w.word;   // loadWord
        endcase
    endfunction

    task automatic checkWord(input string name, input memPkg::busWord_u expected,
                             input memPkg::busWord_u actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, expected.word, actual.word);
        end
    endtask

    task automatic checkData(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkState(input string name, input memPkg::handlerState_e expected,
                              input memPkg::handlerState_e actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %s, actual %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic addEntry(input string name, input logic [31:0] pcVal,
                            input memPkg::memOp_e op, input logic [31:0] adr,
                            input logic src, input logic signMix);
        rngState       = xorshift(rngState);
        tReg[tableLen] = rngState;
        rngState       = xorshift(rngState);
        tFpu[tableLen] = rngState;
        if (signMix) begin
            // Lanes 0 and 3 get the top bit set, lanes 1 and 2 clear
            tReg[tableLen] = (tReg[tableLen] | 32'h8000_0080) & 32'hFF7F_7FFF;
            tFpu[tableLen] = (tFpu[tableLen] | 32'h8000_0080) & 32'hFF7F_7FFF;
        end
        tName[tableLen] = name;
        tPc[tableLen]   = pcVal;
        tOp[tableLen]   = op;
        tAdr[tableLen]  = adr;
        tSrc[tableLen]  = src;
        tableLen++;
    endtask

    // Returns on the edge that closes the done cycle
    task automatic waitDone(input string name, input memPkg::handlerState_e doneState);
        logic seen;
        seen        = 1'b0;
        currentTest = name;
        while (!seen) begin
            @(posedge clk);
            seen = (done === 1'b1);
            checkFlag({name, " freeze"}, !seen, freeze); // Low only with done
        end
        checkState({name, " done state"}, doneState, state); // Fetch ack or data ack
    endtask

    task automatic checkEntry(input int i);
        logic [31:0] d;
        int          a;
        int          n;
        d = tSrc[i] ? tFpu[i] : tReg[i]; // Store source
        a = tAdr[i];
        checkState({tName[i], " next state"}, memPkg::fetch, state);
        if (!$isunknown(modelWord(tPc[i]))) begin
            checkWord({tName[i], " instr"}, modelWord(tPc[i]), instr); // Fetched before any store
        end
        case (tOp[i])
            memPkg::storeByte: n = 1;
            memPkg::storeHalf: n = 2;
            memPkg::storeWord: n = 4;
            default:           n = 0;
        endcase
        for (int k = 0; k < n; k++) modelMem[a + k] = d[8*k +: 8]; // Low byte at low address
        if ((n == 0) && (tOp[i] != memPkg::none)) begin
            expLoad   = expectedLoad(tOp[i], a);
            loadKnown = 1'b1;
        end
        if (loadKnown) checkData({tName[i], " loadData"}, expLoad, loadData); // Holds unless load
    endtask

    initial begin
        nrst       = 1'b0;
        pc         = 32'h0;
        memOp      = memPkg::none; // Reset fetch skips the data phase
        aluAddress = 32'h0;
        memSource  = 1'b0;
        regData    = 32'h0;
        fpuData    = 32'h0;
        addEntry("swReg",       32'h000, memPkg::storeWord, 32'h100, 1'b0, 1'b0);
        addEntry("lwReg",       32'h004, memPkg::loadWord,  32'h100, 1'b0, 1'b0);
        addEntry("swFpu",       32'h008, memPkg::storeWord, 32'h104, 1'b1, 1'b0);
        addEntry("lwFpu",       32'h100, memPkg::loadWord,  32'h104, 1'b0, 1'b0);
        addEntry("fetchStored", 32'h104, memPkg::none,      32'h000, 1'b0, 1'b0);
        addEntry("sbLane0",     32'h00C, memPkg::storeByte, 32'h100, 1'b0, 1'b0);
        addEntry("sbLane3",     32'h010, memPkg::storeByte, 32'h103, 1'b1, 1'b0);
        addEntry("lwAfterSb03", 32'h014, memPkg::loadWord,  32'h100, 1'b0, 1'b0);
        addEntry("sbLane1",     32'h018, memPkg::storeByte, 32'h105, 1'b1, 1'b0);
        addEntry("sbLane2",     32'h01C, memPkg::storeByte, 32'h106, 1'b0, 1'b0);
        addEntry("shUpper",     32'h020, memPkg::storeHalf, 32'h102, 1'b1, 1'b0);
        addEntry("lwAfterShU",  32'h104, memPkg::loadWord,  32'h100, 1'b0, 1'b0); // Fetch sees sb12
        addEntry("shLower",     32'h024, memPkg::storeHalf, 32'h104, 1'b0, 1'b0);
        addEntry("swSignMix",   32'h104, memPkg::storeWord, 32'h108, 1'b0, 1'b1); // Fetch sees shL
        addEntry("lbSet",       32'h108, memPkg::loadByte,  32'h108, 1'b0, 1'b0);
        addEntry("lbClear",     32'h028, memPkg::loadByte,  32'h10A, 1'b0, 1'b0);
        addEntry("lbuSet",      32'h02C, memPkg::loadByteU, 32'h10B, 1'b0, 1'b0);
        addEntry("lbuClear",    32'h030, memPkg::loadByteU, 32'h109, 1'b0, 1'b0);
        addEntry("lhClear",     32'h034, memPkg::loadHalf,  32'h108, 1'b0, 1'b0);
        addEntry("lhSet",       32'h038, memPkg::loadHalf,  32'h10A, 1'b0, 1'b0);
        addEntry("lhuClear",    32'h03C, memPkg::loadHalfU, 32'h108, 1'b0, 1'b0);
        addEntry("lhuSet",      32'h040, memPkg::loadHalfU, 32'h10A, 1'b0, 1'b0);
        addEntry("noneKeep",    32'h108, memPkg::none,      32'h104, 1'b1, 1'b0);
        addEntry("lwAfterNone", 32'h044, memPkg::loadWord,  32'h104, 1'b0, 1'b0);
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        checkState("reset state", memPkg::fetch, state);
        checkFlag("reset freeze", 1'b1, freeze);
        checkFlag("reset done", 1'b0, done);
        waitDone("reset fetch", memPkg::fetchWait);
        for (int i = 0; i < tableLen; i++) begin
            pc         <= tPc[i]; // New instruction right after the previous done
            memOp      <= tOp[i];
            aluAddress <= tAdr[i];
            memSource  <= tSrc[i];
            regData    <= tReg[i];
            fpuData    <= tFpu[i];
            @(negedge clk); // Previous entry's registered outputs settled
            if (i > 0) checkEntry(i - 1);
            waitDone(tName[i], (tOp[i] == memPkg::none) ? memPkg::fetchWait : memPkg::dataWait);
        end
        @(negedge clk);
        checkEntry(tableLen - 1); // Last entry has no successor
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
